// ==== pcw_io_pkg.sv ====
// PCW I/O gate array definitions
`default_nettype none

package pcw_io_pkg;

    typedef logic [15:0] cpu_addr_t;     // Z80 address bus
    typedef logic [7:0]  bus_data_t;     // Z80 data bus
    typedef logic [13:0] page_offset_t;  // Offset inside a 16K bank
    typedef logic [3:0]  sys_cmd_t;      // Low nibble of an F8 write

    // Request kinds from the CPU bus adapter
    typedef enum logic [1:0] {
        OP_MEM   = 2'd0,                 // Memory access, translated through paging
        OP_IO_RD = 2'd1,
        OP_IO_WR = 2'd2
    } bus_op_e;

    // Port classes after decode
    typedef enum logic [3:0] {
        PC_PAGE       = 4'd0,            // F0-F3 bank registers
        PC_ROLLER     = 4'd1,            // F5
        PC_YSCROLL    = 4'd2,            // F6
        PC_VIDEO      = 4'd3,            // F7 inverse / enable
        PC_SYSCTL     = 4'd4,            // F8 command write, status read
        PC_TIMER_CLR  = 4'd5,            // F4 read clears the tick count
        PC_PRN_STATUS = 4'd6,            // FC
        PC_PRN_DATA   = 4'd7,            // FD
        PC_UNMAPPED   = 4'd8
    } port_class_e;

    localparam bus_data_t PORT_F0 = 8'hF0;   // First of the four bank ports
    localparam bus_data_t PORT_F4 = 8'hF4;
    localparam bus_data_t PORT_F5 = 8'hF5;
    localparam bus_data_t PORT_F6 = 8'hF6;
    localparam bus_data_t PORT_F7 = 8'hF7;
    localparam bus_data_t PORT_F8 = 8'hF8;
    localparam bus_data_t PORT_FC = 8'hFC;
    localparam bus_data_t PORT_FD = 8'hFD;

    localparam bus_data_t PRINTER_STATUS_REPLY = 8'hF8;  // Printer controller idle
    localparam bus_data_t PRINTER_DATA_REPLY   = 8'hC8;
    localparam bus_data_t UNMAPPED_REPLY       = 8'hFF;  // Floating bus
    localparam bus_data_t VIDEO_CTRL_RESET     = 8'h80;  // Inverse set, display off

    // System control commands on F8
    localparam sys_cmd_t CMD_DISK_NMI  = 4'd2;
    localparam sys_cmd_t CMD_DISK_INT  = 4'd3;
    localparam sys_cmd_t CMD_DISK_OFF  = 4'd4;
    localparam sys_cmd_t CMD_TC_ON     = 4'd5;
    localparam sys_cmd_t CMD_TC_OFF    = 4'd6;
    localparam sys_cmd_t CMD_MOTOR_ON  = 4'd9;
    localparam sys_cmd_t CMD_MOTOR_OFF = 4'd10;
    localparam sys_cmd_t CMD_SPKR_ON   = 4'd11;
    localparam sys_cmd_t CMD_SPKR_OFF  = 4'd12;

endpackage

`default_nettype wire

// ==== pcw_port_decode.sv ====
// Request decode stage
`timescale 1ns/1ns
`default_nettype none

module pcw_port_decode import pcw_io_pkg::*;
(
    input  wire          clk_sys,
    input  wire          reset,

    input  wire          req_valid,
    output logic         req_ready,
    input  bus_op_e      req_op,
    input  cpu_addr_t    req_addr,
    input  bus_data_t    req_data,

    output logic         dec_valid,
    input  wire          dec_ready,
    output bus_op_e      dec_op,
    output port_class_e  dec_class,
    output logic [1:0]   dec_page_sel,
    output cpu_addr_t    dec_addr,
    output bus_data_t    dec_data
);

    port_class_e req_class;      // Class of the incoming port byte
    logic [1:0]  req_page_sel;

    // Stage can take a new request when empty or draining this cycle
    assign req_ready = ~dec_valid | dec_ready;

    // Port byte classification, low address byte is the I/O port
    always_comb
    begin
        req_class = PC_UNMAPPED;                 // Memory accesses carry no port class
        if (req_op != OP_MEM)
        begin
            if (req_addr[7:2] == PORT_F0[7:2])
                req_class = PC_PAGE;             // F0-F3
            else
            begin
                case (req_addr[7:0])
                    PORT_F4: req_class = PC_TIMER_CLR;
                    PORT_F5: req_class = PC_ROLLER;
                    PORT_F6: req_class = PC_YSCROLL;
                    PORT_F7: req_class = PC_VIDEO;
                    PORT_F8: req_class = PC_SYSCTL;
                    PORT_FC: req_class = PC_PRN_STATUS;
                    PORT_FD: req_class = PC_PRN_DATA;
                    default: req_class = PC_UNMAPPED;
                endcase
            end
        end
    end

    // Bank select: top address bits for memory, port bits for F0-F3
    assign req_page_sel = (req_op == OP_MEM) ? req_addr[15:14] : req_addr[1:0];

    always_ff @(posedge clk_sys)
    begin
        if (reset)
            dec_valid <= 1'b0;
        else if (req_ready)
            dec_valid <= req_valid;              // Empties if nothing new arrives
    end

    // Payload only moves on a handshake
    always_ff @(posedge clk_sys)
    begin
        if (req_valid && req_ready)
        begin
            dec_op       <= req_op;
            dec_class    <= req_class;
            dec_page_sel <= req_page_sel;
            dec_addr     <= req_addr;
            dec_data     <= req_data;
        end
    end

endmodule

`default_nettype wire

// ==== pcw_gate_array.sv ====
// Gate array execute stage
`timescale 1ns/1ns
`default_nettype none

module pcw_gate_array import pcw_io_pkg::*;
#(
    parameter int PAGE_BITS = 4              // Bank bits taken from each page register
)
(
    input  wire                        clk_sys,
    input  wire                        reset,

    input  wire                        dec_valid,
    output logic                       dec_ready,
    input  bus_op_e                    dec_op,
    input  port_class_e                dec_class,
    input  wire [1:0]                  dec_page_sel,
    input  cpu_addr_t                  dec_addr,
    input  bus_data_t                  dec_data,

    input  wire                        vblank,
    input  wire                        ntsc,
    input  wire [3:0]                  timer_misses,
    input  wire                        disk_status,

    output logic                       rsp_valid,
    input  wire                        rsp_ready,
    output bus_op_e                    rsp_op,
    output bus_data_t                  rsp_data,
    output logic [PAGE_BITS+13:0]      rsp_phys_addr,

    output bus_data_t                  roller_ptr,
    output bus_data_t                  yscroll,
    output logic                       video_inverse,
    output logic                       video_enable,
    output logic                       motor,
    output logic                       fdc_tc,
    output logic                       speaker_enable,

    output logic                       sys_cmd_valid,
    output sys_cmd_t                   sys_cmd,
    output logic                       timer_clear_start
);

    bus_data_t                 page_reg [4];    // F0-F3 bank map
    bus_data_t                 video_ctrl;      // F7
    bus_data_t                 status_byte;     // F8 read value
    bus_data_t                 rd_data;
    page_offset_t              offset;
    logic [PAGE_BITS+13:0]     phys_addr;
    logic                      accept;
    logic                      io_wr;
    logic                      io_rd;

    assign dec_ready = ~rsp_valid | rsp_ready;      // Response slot free or leaving
    assign accept    = dec_valid & dec_ready;
    assign io_wr     = accept & (dec_op == OP_IO_WR);
    assign io_rd     = accept & (dec_op == OP_IO_RD);

    // Strobes to the interrupt controller, acted on at the accept edge
    assign sys_cmd_valid     = io_wr & (dec_class == PC_SYSCTL);
    assign sys_cmd           = dec_data[3:0];
    assign timer_clear_start = io_rd & (dec_class == PC_TIMER_CLR);

    assign video_inverse = video_ctrl[7];
    assign video_enable  = video_ctrl[6];

    // Paging: bank number from the selected register, offset from the CPU
    assign offset    = dec_addr[13:0];
    assign phys_addr = {page_reg[dec_page_sel][PAGE_BITS-1:0], offset};

    // NTSC bit reads back inverted
    assign status_byte = {1'b0, vblank, disk_status, ~ntsc, timer_misses};

    always_comb
    begin
        rd_data = '0;                               // Writes and memory return zero
        if (dec_op == OP_IO_RD)
        begin
            case (dec_class)
                PC_SYSCTL,
                PC_TIMER_CLR:  rd_data = status_byte;    // F4 reads like F8
                PC_PRN_STATUS: rd_data = PRINTER_STATUS_REPLY;
                PC_PRN_DATA:   rd_data = PRINTER_DATA_REPLY;
                default:       rd_data = UNMAPPED_REPLY; // Write-only ports too
            endcase
        end
    end

    // Register writes and system commands
    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            for (int i = 0; i < 4; i++)
                page_reg[i] <= '0;
            roller_ptr     <= '0;
            yscroll        <= '0;
            video_ctrl     <= VIDEO_CTRL_RESET;
            motor          <= 1'b0;
            fdc_tc         <= 1'b0;
            speaker_enable <= 1'b0;
        end
        else if (io_wr)
        begin
            case (dec_class)
                PC_PAGE:    page_reg[dec_page_sel] <= dec_data;
                PC_ROLLER:  roller_ptr <= dec_data;
                PC_YSCROLL: yscroll    <= dec_data;
                PC_VIDEO:   video_ctrl <= dec_data;
                PC_SYSCTL:
                begin
                    case (sys_cmd)
                        CMD_TC_ON:     fdc_tc <= 1'b1;
                        CMD_TC_OFF:    fdc_tc <= 1'b0;
                        CMD_MOTOR_ON:  motor  <= 1'b1;
                        CMD_MOTOR_OFF: motor  <= 1'b0;
                        CMD_SPKR_ON:   speaker_enable <= 1'b1;
                        CMD_SPKR_OFF:  speaker_enable <= 1'b0;
                        default: ;                  // Routing handled in interrupt block
                    endcase
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_sys)
    begin
        if (reset)
            rsp_valid <= 1'b0;
        else if (accept)
            rsp_valid <= 1'b1;
        else if (rsp_ready)
            rsp_valid <= 1'b0;
    end

    // Response payload, status sampled at the accept edge
    always_ff @(posedge clk_sys)
    begin
        if (accept)
        begin
            rsp_op        <= dec_op;
            rsp_data      <= rd_data;
            rsp_phys_addr <= (dec_op == OP_MEM) ? phys_addr : '0;
        end
    end

endmodule

`default_nettype wire

// ==== pcw_interrupt_ctrl.sv ====
// Timer and disk interrupt controller
`timescale 1ns/1ns
`default_nettype none

module pcw_interrupt_ctrl import pcw_io_pkg::*;
#(
    parameter int TIMER_CLEAR_CYCLES = 32    // Delay from F4 read to count clear
)
(
    input  wire         clk_sys,
    input  wire         reset,

    input  wire         vid_timer,           // 300 Hz tick from video
    input  wire         fdc_int,             // Disk controller interrupt
    input  wire         iff1,                // CPU interrupt enable

    input  wire         sys_cmd_valid,
    input  sys_cmd_t    sys_cmd,
    input  wire         timer_clear_start,

    output logic [3:0]  timer_misses,
    output logic        disk_status,
    output logic        nmi_req,
    output logic        int_req
);

    localparam int CNT_W = $clog2(TIMER_CLEAR_CYCLES + 1);

    logic              vid_timer_d;
    logic              fdc_int_d;
    logic              timer_pe;
    logic              fdc_pe;
    logic              fdc_ne;
    logic              route_nmi;             // Disk interrupt goes to NMI
    logic              route_int;             // Disk interrupt goes to INT
    logic              nmi_pending;
    logic              nmi_line;
    logic              timer_line;
    logic              disk_int_line;
    logic              clear_active;
    logic [CNT_W-1:0]  clear_count;

    assign timer_pe = vid_timer & ~vid_timer_d;
    assign fdc_pe   = fdc_int & ~fdc_int_d;
    assign fdc_ne   = ~fdc_int & fdc_int_d;

    assign nmi_req = nmi_line;
    assign int_req = timer_line | disk_int_line;   // Timer and disk share INT

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            vid_timer_d   <= 1'b0;
            fdc_int_d     <= 1'b0;
            timer_misses  <= '0;
            disk_status   <= 1'b0;
            route_nmi     <= 1'b0;
            route_int     <= 1'b0;
            nmi_pending   <= 1'b0;
            nmi_line      <= 1'b0;
            timer_line    <= 1'b0;
            disk_int_line <= 1'b0;
            clear_active  <= 1'b0;
            clear_count   <= '0;
        end
        else
        begin
            vid_timer_d <= vid_timer;
            fdc_int_d   <= fdc_int;

            // Disk status latch follows the controller's interrupt edges
            if (fdc_pe)
            begin
                disk_status <= 1'b1;
                if (route_nmi)
                    nmi_pending <= 1'b1;
            end
            else if (fdc_ne)
                disk_status <= 1'b0;

            // Interrupt lines only change on a timer tick
            if (timer_pe)
            begin
                if (timer_misses != 4'hF)
                    timer_misses <= timer_misses + 4'd1;   // Saturates at 15
                timer_line    <= iff1;
                nmi_line      <= nmi_pending;
                disk_int_line <= route_int & disk_status & iff1;
            end

            if (sys_cmd_valid)
            begin
                case (sys_cmd)
                    CMD_DISK_NMI:
                    begin
                        route_nmi <= 1'b1;
                        route_int <= 1'b0;
                    end
                    CMD_DISK_INT:
                    begin
                        route_nmi   <= 1'b0;
                        route_int   <= 1'b1;
                        nmi_pending <= 1'b0;
                    end
                    CMD_DISK_OFF:
                    begin
                        route_nmi     <= 1'b0;
                        route_int     <= 1'b0;
                        nmi_pending   <= 1'b0;
                        disk_int_line <= 1'b0;
                    end
                    default: ;                     // Other commands live in the gate array
                endcase
            end

            // Delayed count clear after an F4 read, a new read restarts it
            if (timer_clear_start)
            begin
                clear_active <= 1'b1;
                clear_count  <= '0;
            end
            else if (clear_active)
            begin
                if (clear_count == CNT_W'(TIMER_CLEAR_CYCLES - 1))
                begin
                    clear_active <= 1'b0;
                    timer_misses <= '0;            // Wins over a tick in the same cycle
                    timer_line   <= 1'b0;
                end
                else
                    clear_count <= clear_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== pcw_io_top.sv ====
// PCW I/O gate array top
`timescale 1ns/1ns
`default_nettype none

module pcw_io_top import pcw_io_pkg::*;
#(
    parameter int PAGE_BITS          = 4,    // 256K of banked memory
    parameter int TIMER_CLEAR_CYCLES = 32
)
(
    input  wire                    clk_sys,
    input  wire                    reset,

    input  wire                    req_valid,
    output logic                   req_ready,
    input  bus_op_e                req_op,
    input  cpu_addr_t              req_addr,
    input  bus_data_t              req_data,

    output logic                   rsp_valid,
    input  wire                    rsp_ready,
    output bus_op_e                rsp_op,
    output bus_data_t              rsp_data,
    output logic [PAGE_BITS+13:0]  rsp_phys_addr,

    input  wire                    vblank,
    input  wire                    ntsc,
    input  wire                    vid_timer,
    input  wire                    fdc_int,
    input  wire                    iff1,

    output bus_data_t              roller_ptr,
    output bus_data_t              yscroll,
    output logic                   video_inverse,
    output logic                   video_enable,
    output logic                   motor,
    output logic                   fdc_tc,
    output logic                   speaker_enable,
    output logic                   nmi_req,
    output logic                   int_req
);

    // Decode to execute
    logic         dec_valid;
    logic         dec_ready;
    bus_op_e      dec_op;
    port_class_e  dec_class;
    logic [1:0]   dec_page_sel;
    cpu_addr_t    dec_addr;
    bus_data_t    dec_data;

    // Execute to and from the interrupt controller
    logic         sys_cmd_valid;
    sys_cmd_t     sys_cmd;
    logic         timer_clear_start;
    logic [3:0]   timer_misses;
    logic         disk_status;

    pcw_port_decode u_decode (.*);

    pcw_gate_array #(
        .PAGE_BITS(PAGE_BITS)
    ) u_gate_array (.*);

    pcw_interrupt_ctrl #(
        .TIMER_CLEAR_CYCLES(TIMER_CLEAR_CYCLES)
    ) u_interrupt_ctrl (.*);

endmodule

`default_nettype wire

// ==== tb_pcw_model.svh ====
// PCW I/O reference model
`ifndef TB_PCW_MODEL_SVH
`define TB_PCW_MODEL_SVH

logic [7:0]        m_page [4];                  // Expected F0-F3 contents
logic [7:0]        m_roller;
logic [7:0]        m_yscroll;
logic [7:0]        m_video;                     // Bit 7 inverse, bit 6 enable
logic              m_motor;
logic              m_tc;
logic              m_speaker;
logic [3:0]        m_ticks;                     // Missed ticks, saturates at 15
logic              m_disk;                      // Latched disk interrupt

// Expected responses, oldest first
bus_op_e           q_op   [$];
logic [7:0]        q_data [$];
logic [PHYS_W-1:0] q_phys [$];
time               q_time [$];                  // Time of the request handshake
logic              q_lat  [$];                  // Latency checked for this entry

task automatic model_reset();
    for (int i = 0; i < 4; i++)
        m_page[i] = 8'h00;
    m_roller  = 8'h00;
    m_yscroll = 8'h00;
    m_video   = 8'h80;                          // Inverse on, display off
    m_motor   = 1'b0;
    m_tc      = 1'b0;
    m_speaker = 1'b0;
    m_ticks   = 4'd0;
    m_disk    = 1'b0;
endtask

// F8 commands that reach outputs of the gate array
task automatic sys_command(input logic [3:0] cmd);
    case (cmd)
        4'd5:    m_tc      = 1'b1;
        4'd6:    m_tc      = 1'b0;
        4'd9:    m_motor   = 1'b1;
        4'd10:   m_motor   = 1'b0;
        4'd11:   m_speaker = 1'b1;
        4'd12:   m_speaker = 1'b0;
        default: ;                              // Routing codes and unused ones
    endcase
endtask

// Applies one request to the model and queues its response
task automatic model_request(input bus_op_e op, input logic [15:0] addr, input logic [7:0] data);
    logic [7:0]        port;
    logic [7:0]        rdata;
    logic [PHYS_W-1:0] phys;
    port  = addr[7:0];
    rdata = 8'h00;
    phys  = '0;
    if (op == OP_MEM)
        phys = {m_page[addr[15:14]][PAGE_BITS-1:0], addr[13:0]};
    else if (op == OP_IO_RD)
    begin
        case (port)
            8'hF4, 8'hF8: rdata = {1'b0, vblank, m_disk, ~ntsc, m_ticks};
            8'hFC:        rdata = 8'hF8;            // Printer idle
            8'hFD:        rdata = 8'hC8;
            default:      rdata = 8'hFF;
        endcase
    end
    else if (port[7:2] == 6'h3C)                // F0-F3
        m_page[port[1:0]] = data;
    else if (port == 8'hF5)
        m_roller = data;
    else if (port == 8'hF6)
        m_yscroll = data;
    else if (port == 8'hF7)
        m_video = data;
    else if (port == 8'hF8)
        sys_command(data[3:0]);
    q_op.push_back(op);
    q_data.push_back(rdata);
    q_phys.push_back(phys);
    q_time.push_back($time);
    q_lat.push_back(!bp_on);
endtask

`endif

// ==== tb_pcw_io.sv ====
// PCW I/O gate array testbench
`timescale 1ns/1ns
`default_nettype none

module tb_pcw_io import pcw_io_pkg::*;
();

    localparam int PAGE_BITS          = 4;
    localparam int TIMER_CLEAR_CYCLES = 32;
    localparam int PHYS_W             = PAGE_BITS + 14;
    localparam int TIMEOUT            = 200;        // Cycles allowed per wait

    logic              clk_sys;
    logic              reset;
    logic              req_valid;
    logic              req_ready;
    bus_op_e           req_op;
    cpu_addr_t         req_addr;
    bus_data_t         req_data;
    logic              rsp_valid;
    logic              rsp_ready;
    bus_op_e           rsp_op;
    bus_data_t         rsp_data;
    logic [PHYS_W-1:0] rsp_phys_addr;
    logic              vblank;
    logic              ntsc;
    logic              vid_timer;
    logic              fdc_int;
    logic              iff1;
    bus_data_t         roller_ptr;
    bus_data_t         yscroll;
    logic              video_inverse;
    logic              video_enable;
    logic              motor;
    logic              fdc_tc;
    logic              speaker_enable;
    logic              nmi_req;
    logic              int_req;
    logic              bp_on;                       // Random stalls on rsp_ready
    int                errors;
    int                timeouts;

    `include "tb_pcw_model.svh"

    pcw_io_top #(
        .PAGE_BITS(PAGE_BITS),
        .TIMER_CLEAR_CYCLES(TIMER_CLEAR_CYCLES)
    ) DUT (.*);

    initial
    begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;             // 50 MHz
    end

    // About 40% low while back-pressure is on
    always @(posedge clk_sys)
    begin
        #2;
        rsp_ready = bp_on ? ($urandom_range(99) >= 40) : 1'b1;
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else
        begin
            errors++;
            $display("MISMATCH t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
        end
    endtask

    task automatic check_response();
        time  t;
        logic lat;
        t   = q_time.pop_front();
        lat = q_lat.pop_front();
        check_val("rsp_op", q_op.pop_front(), rsp_op);
        check_val("rsp_data", q_data.pop_front(), rsp_data);
        check_val("rsp_phys_addr", q_phys.pop_front(), rsp_phys_addr);
        if (lat)
            check_val("rsp_latency_ns", 32'd40, 32'($time - t));    // Two clock periods
    endtask

    // Response monitor sampling at the handshake edge
    always @(posedge clk_sys)
    begin
        if (!reset && rsp_valid && rsp_ready)
        begin
            assert (q_op.size() != 0)
            else
            begin
                errors++;
                $display("ERROR t=%0t response arrived with no request outstanding", $time);
            end
            if (q_op.size() != 0)
                check_response();
        end
    end

    // Called 2 ns after an edge and returns 2 ns after the handshake edge
    task automatic send_req(input bus_op_e op, input logic [15:0] addr, input logic [7:0] data);
        int n;
        n         = 0;
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_data  = data;
        @(posedge clk_sys);
        while (!req_ready && n < TIMEOUT)
        begin
            n++;
            @(posedge clk_sys);
        end
        assert (req_ready)
        else
        begin
            timeouts++;
            $display("TIMEOUT t=%0t request at %h was never accepted", $time, addr);
        end
        if (req_ready)
            model_request(op, addr, data);
        #2;
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while ((q_op.size() != 0 || rsp_valid) && n < TIMEOUT)
        begin
            @(posedge clk_sys);
            #2;
            n++;
        end
        assert (q_op.size() == 0 && !rsp_valid)
        else
        begin
            timeouts++;
            $display("TIMEOUT t=%0t responses still outstanding", $time);
        end
    endtask

    // F4 read and then the wait for the delayed count clear
    task automatic clear_ticks();
        send_req(OP_IO_RD, 16'h00F4, 8'h00);
        wait_idle();
        repeat (TIMER_CLEAR_CYCLES + 4) @(posedge clk_sys);
        #2;
        m_ticks = 4'd0;
    endtask

    task automatic timer_tick();
        vid_timer = 1'b1;
        @(posedge clk_sys);                         // Edge detected here
        #2;
        vid_timer = 1'b0;
        @(posedge clk_sys);
        #2;
        if (m_ticks != 4'd15)
            m_ticks++;
    endtask

    task automatic set_fdc(input logic value);
        fdc_int = value;
        @(posedge clk_sys);
        #2;
        m_disk = value;
    endtask

    task automatic check_outputs();
        check_val("roller_ptr", m_roller, roller_ptr);
        check_val("yscroll", m_yscroll, yscroll);
        check_val("video_inverse", m_video[7], video_inverse);
        check_val("video_enable", m_video[6], video_enable);
        check_val("motor", m_motor, motor);
        check_val("fdc_tc", m_tc, fdc_tc);
        check_val("speaker_enable", m_speaker, speaker_enable);
    endtask

    function automatic logic [7:0] pick_read_port();
        logic [7:0] port;
        port = 8'($urandom);
        if (port == 8'hF4 || $urandom_range(3) == 0)    // F4 would start a count clear
            port = ($urandom_range(1) == 0) ? 8'hFC : 8'hFD;
        return port;
    endfunction

    initial
    begin
        errors    = 0;
        timeouts  = 0;
        bp_on     = 1'b0;
        reset     = 1'b1;
        req_valid = 1'b0;
        req_op    = OP_MEM;
        req_addr  = 16'h0000;
        req_data  = 8'h00;
        rsp_ready = 1'b1;
        vblank    = 1'b0;
        ntsc      = 1'b0;
        vid_timer = 1'b0;
        fdc_int   = 1'b0;
        iff1      = 1'b0;
        void'($urandom(64));
        model_reset();
        repeat (2) @(posedge clk_sys);
        #2;
        reset = 1'b0;
        check_outputs();                            // Reset values
        check_val("rsp_valid", 0, rsp_valid);
        check_val("nmi_req", 0, nmi_req);
        check_val("int_req", 0, int_req);

        // Paging mixed with port reads
        repeat (200)
        begin
            case ($urandom_range(3))
                0: send_req(OP_IO_WR, {8'($urandom), 6'h3C, 2'($urandom_range(3))}, 8'($urandom));
                1: send_req(OP_IO_RD, {8'($urandom), pick_read_port()}, 8'h00);
                default: send_req(OP_MEM, 16'($urandom), 8'($urandom));
            endcase
        end
        wait_idle();

        // Video registers and system commands with outputs checked after each
        repeat (80)
        begin
            send_req(OP_IO_WR, {8'h00, 8'hF5 + 8'($urandom_range(3))}, 8'($urandom));
            wait_idle();
            check_outputs();
        end

        // Status byte against inputs and tick count
        repeat (10)
        begin
            vblank = 1'($urandom);
            ntsc   = 1'($urandom);
            set_fdc(1'($urandom));
            repeat ($urandom_range(3)) timer_tick();
            send_req(OP_IO_RD, 16'h00F8, 8'h00);
            wait_idle();
        end
        repeat (20) timer_tick();                   // Saturate the count
        send_req(OP_IO_RD, 16'h00F8, 8'h00);
        clear_ticks();
        send_req(OP_IO_RD, 16'h00F8, 8'h00);
        wait_idle();
        set_fdc(1'b0);

        // NMI routing
        send_req(OP_IO_WR, 16'h00F8, 8'h04);
        send_req(OP_IO_WR, 16'h00F8, 8'h02);
        wait_idle();
        set_fdc(1'b1);
        timer_tick();
        check_val("nmi_req", 1, nmi_req);
        check_val("int_req", 0, int_req);
        // INT routing
        send_req(OP_IO_WR, 16'h00F8, 8'h03);
        wait_idle();
        iff1 = 1'b1;
        timer_tick();
        check_val("int_req", 1, int_req);
        check_val("nmi_req", 0, nmi_req);
        clear_ticks();                              // Timer line cleared so only disk INT remains
        check_val("int_req", 1, int_req);
        // Disconnected
        send_req(OP_IO_WR, 16'h00F8, 8'h04);
        wait_idle();
        check_val("int_req", 0, int_req);           // Disk INT line dropped by the command
        iff1 = 1'b0;
        timer_tick();
        check_val("int_req", 0, int_req);
        set_fdc(1'b0);

        // Random traffic under back-pressure
        bp_on = 1'b1;
        repeat (300)
        begin
            case ($urandom_range(4))
                0: send_req(OP_IO_WR, {8'h00, 6'h3C, 2'($urandom_range(3))}, 8'($urandom));
                1: send_req(OP_IO_WR, {8'h00, 8'hF5 + 8'($urandom_range(3))}, 8'($urandom));
                2: send_req(OP_IO_RD, {8'($urandom), pick_read_port()}, 8'h00);
                default: send_req(OP_MEM, 16'($urandom), 8'h00);
            endcase
        end
        wait_idle();
        bp_on = 1'b0;
        check_outputs();

        $display("Run complete: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
pcw_io_pkg.sv
pcw_port_decode.sv
pcw_gate_array.sv
pcw_interrupt_ctrl.sv
pcw_io_top.sv
tb_pcw_io.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the PCW I/O testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_pcw_io -o tb_pcw_io \
    && ./obj_dir/tb_pcw_io > sim.log 2>&1 \
    || echo "Build or simulation did not complete"

cat sim.log 2>/dev/null

grep -q "ALL CHECKS PASSED" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }
